// ==== ls_issue.f ====
rtl/ls_pkg.sv
rtl/phys_ready_table.sv
rtl/phys_regfile.sv
rtl/ls_station.sv
rtl/agu_stage.sv
rtl/ls_issue_top.sv
sim/ls_issue_tb.sv

// ==== rtl/agu_stage.sv ====
`timescale 1ns/1ps

module agu_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          flush,
  input  logic                          issue_valid,
  input  logic [ls_pkg::INST_NUM_W-1:0] issue_inst_num,
  input  logic [ls_pkg::TAG_W-1:0]      issue_rd,
  input  logic                          issue_is_store,
  input  logic [ls_pkg::FUNCT3_W-1:0]   issue_funct3,
  input  logic [ls_pkg::IMM_W-1:0]      issue_imm,
  input  logic [ls_pkg::DATA_W-1:0]     src1_value,
  input  logic [ls_pkg::DATA_W-1:0]     src2_value,
  output logic                          mem_req_valid,
  output logic                          mem_req_is_store,
  output logic [ls_pkg::DATA_W-1:0]     mem_req_addr,
  output logic [ls_pkg::DATA_W-1:0]     mem_req_wdata,
  output logic [ls_pkg::FUNCT3_W-1:0]   mem_req_funct3,
  output logic [ls_pkg::TAG_W-1:0]      mem_req_rd,
  output logic [ls_pkg::INST_NUM_W-1:0] mem_req_inst_num
);

  logic [ls_pkg::DATA_W-1:0] eff_addr;
  logic [ls_pkg::DATA_W-1:0] store_data;

  // Base plus offset
  assign eff_addr   = src1_value + issue_imm;
  assign store_data = issue_is_store ? src2_value : '0;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      mem_req_valid <= 1'b0;
    end else begin
      mem_req_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      mem_req_is_store <= issue_is_store;
      mem_req_addr     <= eff_addr;
      mem_req_wdata    <= store_data;
      mem_req_funct3   <= issue_funct3;
      mem_req_rd       <= issue_rd;
      mem_req_inst_num <= issue_inst_num;
    end
  end

endmodule

// ==== rtl/ls_issue_top.sv ====
`timescale 1ns/1ps

module ls_issue_top (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     flush,
  input  logic                                     dispatch_valid,
  input  logic [ls_pkg::INST_NUM_W-1:0]            dispatch_inst_num,
  input  logic [ls_pkg::TAG_W-1:0]                 dispatch_rd,
  input  logic                                     dispatch_is_store,
  input  logic [ls_pkg::FUNCT3_W-1:0]              dispatch_funct3,
  input  logic [ls_pkg::IMM_W-1:0]                 dispatch_imm,
  input  logic [ls_pkg::TAG_W-1:0]                 dispatch_src1,
  input  logic [ls_pkg::TAG_W-1:0]                 dispatch_src2,
  input  logic [ls_pkg::NUM_WB-1:0]                wb_valid,
  input  logic [ls_pkg::NUM_WB*ls_pkg::TAG_W-1:0]  wb_tag,
  input  logic [ls_pkg::NUM_WB*ls_pkg::DATA_W-1:0] wb_data,
  output logic                                     station_full,
  output logic                                     mem_req_valid,
  output logic                                     mem_req_is_store,
  output logic [ls_pkg::DATA_W-1:0]                mem_req_addr,
  output logic [ls_pkg::DATA_W-1:0]                mem_req_wdata,
  output logic [ls_pkg::FUNCT3_W-1:0]              mem_req_funct3,
  output logic [ls_pkg::TAG_W-1:0]                 mem_req_rd,
  output logic [ls_pkg::INST_NUM_W-1:0]            mem_req_inst_num
);

  logic                          src1_ready;
  logic                          src2_ready;
  logic                          issue_valid;
  logic [ls_pkg::INST_NUM_W-1:0] issue_inst_num;
  logic [ls_pkg::TAG_W-1:0]      issue_rd;
  logic                          issue_is_store;
  logic [ls_pkg::FUNCT3_W-1:0]   issue_funct3;
  logic [ls_pkg::IMM_W-1:0]      issue_imm;
  logic [ls_pkg::TAG_W-1:0]      issue_src1;
  logic [ls_pkg::TAG_W-1:0]      issue_src2;
  logic [ls_pkg::DATA_W-1:0]     src1_value;
  logic [ls_pkg::DATA_W-1:0]     src2_value;

  phys_ready_table u_ready (
    .clk               (clk),
    .rst               (rst),
    .flush             (flush),
    .wb_valid          (wb_valid),
    .wb_tag            (wb_tag),
    .dispatch_valid    (dispatch_valid),
    .dispatch_is_store (dispatch_is_store),
    .dispatch_rd       (dispatch_rd),
    .dispatch_src1     (dispatch_src1),
    .dispatch_src2     (dispatch_src2),
    .src1_ready        (src1_ready),
    .src2_ready        (src2_ready)
  );

  phys_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .wb_valid (wb_valid),
    .wb_tag   (wb_tag),
    .wb_data  (wb_data),
    .rd_tag1  (issue_src1),
    .rd_tag2  (issue_src2),
    .rd_data1 (src1_value),
    .rd_data2 (src2_value)
  );

  ls_station u_station (
    .clk               (clk),
    .rst               (rst),
    .flush             (flush),
    .dispatch_valid    (dispatch_valid),
    .dispatch_inst_num (dispatch_inst_num),
    .dispatch_rd       (dispatch_rd),
    .dispatch_is_store (dispatch_is_store),
    .dispatch_funct3   (dispatch_funct3),
    .dispatch_imm      (dispatch_imm),
    .dispatch_src1     (dispatch_src1),
    .dispatch_src2     (dispatch_src2),
    .src1_ready        (src1_ready),
    .src2_ready        (src2_ready),
    .wb_valid          (wb_valid),
    .wb_tag            (wb_tag),
    .station_full      (station_full),
    .issue_valid       (issue_valid),
    .issue_inst_num    (issue_inst_num),
    .issue_rd          (issue_rd),
    .issue_is_store    (issue_is_store),
    .issue_funct3      (issue_funct3),
    .issue_imm         (issue_imm),
    .issue_src1        (issue_src1),
    .issue_src2        (issue_src2)
  );

  agu_stage u_agu (
    .clk              (clk),
    .rst              (rst),
    .flush            (flush),
    .issue_valid      (issue_valid),
    .issue_inst_num   (issue_inst_num),
    .issue_rd         (issue_rd),
    .issue_is_store   (issue_is_store),
    .issue_funct3     (issue_funct3),
    .issue_imm        (issue_imm),
    .src1_value       (src1_value),
    .src2_value       (src2_value),
    .mem_req_valid    (mem_req_valid),
    .mem_req_is_store (mem_req_is_store),
    .mem_req_addr     (mem_req_addr),
    .mem_req_wdata    (mem_req_wdata),
    .mem_req_funct3   (mem_req_funct3),
    .mem_req_rd       (mem_req_rd),
    .mem_req_inst_num (mem_req_inst_num)
  );

endmodule

// ==== rtl/ls_pkg.sv ====
package ls_pkg;

  // ----------------------------------------------------------------------
  // Physical register file
  // ----------------------------------------------------------------------
  localparam int PHYS_REGS  = 64;
  localparam int TAG_W      = 6;
  localparam int DATA_W     = 32;

  // Instruction fields carried by a dispatch
  localparam int INST_NUM_W = 32;
  localparam int IMM_W      = 32;
  localparam int FUNCT3_W   = 3;

  // ----------------------------------------------------------------------
  // Load/store station
  // ----------------------------------------------------------------------
  localparam int LS_ENTRIES = 8;
  localparam int SLOT_W     = 3;

  // ----------------------------------------------------------------------
  // Completion buses
  // ----------------------------------------------------------------------
  localparam int NUM_WB     = 4;

  // Bus index within wb_valid / wb_tag / wb_data
  localparam int WB_ALU     = 0;
  localparam int WB_MUL     = 1;
  localparam int WB_DIV     = 2;
  localparam int WB_LOAD    = 3;

endpackage

// ==== rtl/ls_station.sv ====
`timescale 1ns/1ps

module ls_station (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    flush,
  input  logic                                    dispatch_valid,
  input  logic [ls_pkg::INST_NUM_W-1:0]           dispatch_inst_num,
  input  logic [ls_pkg::TAG_W-1:0]                dispatch_rd,
  input  logic                                    dispatch_is_store,
  input  logic [ls_pkg::FUNCT3_W-1:0]             dispatch_funct3,
  input  logic [ls_pkg::IMM_W-1:0]                dispatch_imm,
  input  logic [ls_pkg::TAG_W-1:0]                dispatch_src1,
  input  logic [ls_pkg::TAG_W-1:0]                dispatch_src2,
  input  logic                                    src1_ready,
  input  logic                                    src2_ready,
  input  logic [ls_pkg::NUM_WB-1:0]               wb_valid,
  input  logic [ls_pkg::NUM_WB*ls_pkg::TAG_W-1:0] wb_tag,
  output logic                                    station_full,
  output logic                                    issue_valid,
  output logic [ls_pkg::INST_NUM_W-1:0]           issue_inst_num,
  output logic [ls_pkg::TAG_W-1:0]                issue_rd,
  output logic                                    issue_is_store,
  output logic [ls_pkg::FUNCT3_W-1:0]             issue_funct3,
  output logic [ls_pkg::IMM_W-1:0]                issue_imm,
  output logic [ls_pkg::TAG_W-1:0]                issue_src1,
  output logic [ls_pkg::TAG_W-1:0]                issue_src2
);

  // ----------------------------------------------------------------------
  // Entry storage
  // ----------------------------------------------------------------------
  logic [ls_pkg::LS_ENTRIES-1:0] occupied;
  logic [ls_pkg::LS_ENTRIES-1:0] op1_ready;
  logic [ls_pkg::LS_ENTRIES-1:0] op2_ready;
  logic [ls_pkg::LS_ENTRIES-1:0] ent_is_store;
  logic [ls_pkg::INST_NUM_W-1:0] ent_inst_num [ls_pkg::LS_ENTRIES];
  logic [ls_pkg::TAG_W-1:0]      ent_rd       [ls_pkg::LS_ENTRIES];
  logic [ls_pkg::FUNCT3_W-1:0]   ent_funct3   [ls_pkg::LS_ENTRIES];
  logic [ls_pkg::IMM_W-1:0]      ent_imm      [ls_pkg::LS_ENTRIES];
  logic [ls_pkg::TAG_W-1:0]      ent_src1     [ls_pkg::LS_ENTRIES];
  logic [ls_pkg::TAG_W-1:0]      ent_src2     [ls_pkg::LS_ENTRIES];

  logic [ls_pkg::LS_ENTRIES-1:0] wake1;
  logic [ls_pkg::LS_ENTRIES-1:0] wake2;
  logic                          free_found;
  logic [ls_pkg::SLOT_W-1:0]     free_slot;
  logic                          issue_found;
  logic [ls_pkg::SLOT_W-1:0]     issue_slot;

  assign station_full = &occupied;

  // Tag match against every completion bus
  always_comb begin
    wake1 = '0;
    wake2 = '0;
    for (int e = 0; e < ls_pkg::LS_ENTRIES; e++) begin
      for (int b = 0; b < ls_pkg::NUM_WB; b++) begin
        if (occupied[e] && wb_valid[b] &&
            wb_tag[b*ls_pkg::TAG_W +: ls_pkg::TAG_W] == ent_src1[e]) begin
          wake1[e] = 1'b1;
        end
        if (occupied[e] && wb_valid[b] &&
            wb_tag[b*ls_pkg::TAG_W +: ls_pkg::TAG_W] == ent_src2[e]) begin
          wake2[e] = 1'b1;
        end
      end
    end
  end

  // Lowest index wins for both allocation and issue
  always_comb begin
    free_found  = 1'b0;
    free_slot   = '0;
    issue_found = 1'b0;
    issue_slot  = '0;
    for (int e = ls_pkg::LS_ENTRIES - 1; e >= 0; e--) begin
      if (!occupied[e]) begin
        free_found = 1'b1;
        free_slot  = e[ls_pkg::SLOT_W-1:0];
      end
      if (occupied[e] && op1_ready[e] && op2_ready[e]) begin
        issue_found = 1'b1;
        issue_slot  = e[ls_pkg::SLOT_W-1:0];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Occupancy and issue strobe
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      occupied    <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= issue_found;
      if (issue_found) begin
        occupied[issue_slot] <= 1'b0;
      end
      if (dispatch_valid && free_found) begin
        occupied[free_slot] <= 1'b1;
      end
    end
  end

  // Entry fields, operand ready bits and issue payload
  always_ff @(posedge clk) begin
    op1_ready <= op1_ready | wake1;
    op2_ready <= op2_ready | wake2;
    if (dispatch_valid && free_found) begin
      ent_inst_num[free_slot] <= dispatch_inst_num;
      ent_rd[free_slot]       <= dispatch_rd;
      ent_is_store[free_slot] <= dispatch_is_store;
      ent_funct3[free_slot]   <= dispatch_funct3;
      ent_imm[free_slot]      <= dispatch_imm;
      ent_src1[free_slot]     <= dispatch_src1;
      ent_src2[free_slot]     <= dispatch_src2;
      op1_ready[free_slot]    <= src1_ready;
      op2_ready[free_slot]    <= src2_ready;
    end
    if (issue_found) begin
      issue_inst_num <= ent_inst_num[issue_slot];
      issue_rd       <= ent_rd[issue_slot];
      issue_is_store <= ent_is_store[issue_slot];
      issue_funct3   <= ent_funct3[issue_slot];
      issue_imm      <= ent_imm[issue_slot];
      issue_src1     <= ent_src1[issue_slot];
      issue_src2     <= ent_src2[issue_slot];
    end
  end

endmodule

// ==== rtl/phys_ready_table.sv ====
`timescale 1ns/1ps

module phys_ready_table (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    flush,
  input  logic [ls_pkg::NUM_WB-1:0]               wb_valid,
  input  logic [ls_pkg::NUM_WB*ls_pkg::TAG_W-1:0] wb_tag,
  input  logic                                    dispatch_valid,
  input  logic                                    dispatch_is_store,
  input  logic [ls_pkg::TAG_W-1:0]                dispatch_rd,
  input  logic [ls_pkg::TAG_W-1:0]                dispatch_src1,
  input  logic [ls_pkg::TAG_W-1:0]                dispatch_src2,
  output logic                                    src1_ready,
  output logic                                    src2_ready
);

  logic [ls_pkg::PHYS_REGS-1:0] ready_q;
  logic                         src1_hit;
  logic                         src2_hit;

  // Completion in the dispatch cycle counts as ready
  always_comb begin
    src1_hit = 1'b0;
    src2_hit = 1'b0;
    for (int b = 0; b < ls_pkg::NUM_WB; b++) begin
      if (wb_valid[b] && wb_tag[b*ls_pkg::TAG_W +: ls_pkg::TAG_W] == dispatch_src1) begin
        src1_hit = 1'b1;
      end
      if (wb_valid[b] && wb_tag[b*ls_pkg::TAG_W +: ls_pkg::TAG_W] == dispatch_src2) begin
        src2_hit = 1'b1;
      end
    end
  end

  assign src1_ready = ready_q[dispatch_src1] | src1_hit;
  assign src2_ready = ready_q[dispatch_src2] | src2_hit;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      ready_q <= '1;
    end else begin
      for (int b = 0; b < ls_pkg::NUM_WB; b++) begin
        if (wb_valid[b]) begin
          ready_q[wb_tag[b*ls_pkg::TAG_W +: ls_pkg::TAG_W]] <= 1'b1;
        end
      end
      // New load destination is pending until its own completion
      if (dispatch_valid && !dispatch_is_store) begin
        ready_q[dispatch_rd] <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/phys_regfile.sv ====
`timescale 1ns/1ps

module phys_regfile (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [ls_pkg::NUM_WB-1:0]                wb_valid,
  input  logic [ls_pkg::NUM_WB*ls_pkg::TAG_W-1:0]  wb_tag,
  input  logic [ls_pkg::NUM_WB*ls_pkg::DATA_W-1:0] wb_data,
  input  logic [ls_pkg::TAG_W-1:0]                 rd_tag1,
  input  logic [ls_pkg::TAG_W-1:0]                 rd_tag2,
  output logic [ls_pkg::DATA_W-1:0]                rd_data1,
  output logic [ls_pkg::DATA_W-1:0]                rd_data2
);

  logic [ls_pkg::DATA_W-1:0] regs_q [ls_pkg::PHYS_REGS];

  // One write port per completion bus
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < ls_pkg::PHYS_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      for (int b = 0; b < ls_pkg::NUM_WB; b++) begin
        if (wb_valid[b]) begin
          regs_q[wb_tag[b*ls_pkg::TAG_W +: ls_pkg::TAG_W]] <=
            wb_data[b*ls_pkg::DATA_W +: ls_pkg::DATA_W];
        end
      end
    end
  end

  // Read ports for the issued entry
  assign rd_data1 = regs_q[rd_tag1];
  assign rd_data2 = regs_q[rd_tag2];

endmodule

// ==== sim/ls_issue_tb.sv ====
`timescale 1ns/1ps

module ls_issue_tb;

  localparam int MAX_OPS    = 512;
  localparam int RAND_OPS   = 150;
  localparam int PLAN_OPS   = 6 + 8 + 4 + 9 + 6 + RAND_OPS;
  localparam int MAX_CYCLES = 40 * PLAN_OPS + 200;

  typedef struct packed {
    logic [ls_pkg::DATA_W-1:0]   addr;
    logic [ls_pkg::DATA_W-1:0]   wdata;
    logic [ls_pkg::TAG_W-1:0]    rd;
    logic [ls_pkg::FUNCT3_W-1:0] funct3;
    logic                        is_store;
  } mem_req_t;

  logic                                     clk = 1'b0;
  logic                                     rst;
  logic                                     flush;
  logic                                     dispatch_valid;
  logic [ls_pkg::INST_NUM_W-1:0]            dispatch_inst_num;
  logic [ls_pkg::TAG_W-1:0]                 dispatch_rd;
  logic                                     dispatch_is_store;
  logic [ls_pkg::FUNCT3_W-1:0]              dispatch_funct3;
  logic [ls_pkg::IMM_W-1:0]                 dispatch_imm;
  logic [ls_pkg::TAG_W-1:0]                 dispatch_src1;
  logic [ls_pkg::TAG_W-1:0]                 dispatch_src2;
  logic [ls_pkg::NUM_WB-1:0]                wb_valid;
  logic [ls_pkg::NUM_WB*ls_pkg::TAG_W-1:0]  wb_tag;
  logic [ls_pkg::NUM_WB*ls_pkg::DATA_W-1:0] wb_data;
  logic                                     station_full;
  logic                                     mem_req_valid;
  logic                                     mem_req_is_store;
  logic [ls_pkg::DATA_W-1:0]                mem_req_addr;
  logic [ls_pkg::DATA_W-1:0]                mem_req_wdata;
  logic [ls_pkg::FUNCT3_W-1:0]              mem_req_funct3;
  logic [ls_pkg::TAG_W-1:0]                 mem_req_rd;
  logic [ls_pkg::INST_NUM_W-1:0]            mem_req_inst_num;

  // Shadow register file and ready bits
  logic [ls_pkg::DATA_W-1:0] shadow_val [ls_pkg::PHYS_REGS];
  logic                      shadow_rdy [ls_pkg::PHYS_REGS];
  int                        use_cnt    [ls_pkg::PHYS_REGS];

  // Pending list by instruction number
  // State codes are 1 pending, 2 done and 3 flushed
  int                          pend_state [MAX_OPS];
  logic                        pend_store [MAX_OPS];
  logic [ls_pkg::TAG_W-1:0]    pend_rd    [MAX_OPS];
  logic [ls_pkg::TAG_W-1:0]    pend_src1  [MAX_OPS];
  logic [ls_pkg::TAG_W-1:0]    pend_src2  [MAX_OPS];
  logic [ls_pkg::FUNCT3_W-1:0] pend_f3    [MAX_OPS];
  logic [ls_pkg::IMM_W-1:0]    pend_imm   [MAX_OPS];
  int                          pend_edge  [MAX_OPS];
  logic                        pend_lat   [MAX_OPS];

  // Stimulus for the next clock
  logic                                     nx_disp;
  logic                                     nx_flush;
  logic                                     nx_store;
  logic [ls_pkg::INST_NUM_W-1:0]            nx_inst;
  logic [ls_pkg::TAG_W-1:0]                 nx_rd;
  logic [ls_pkg::TAG_W-1:0]                 nx_src1;
  logic [ls_pkg::TAG_W-1:0]                 nx_src2;
  logic [ls_pkg::FUNCT3_W-1:0]              nx_f3;
  logic [ls_pkg::IMM_W-1:0]                 nx_imm;
  logic [ls_pkg::NUM_WB-1:0]                nx_wb_valid;
  logic [ls_pkg::NUM_WB*ls_pkg::TAG_W-1:0]  nx_wb_tag;
  logic [ls_pkg::NUM_WB*ls_pkg::DATA_W-1:0] nx_wb_data;

  int     cycles = 0;
  int     errors = 0;
  int     checks = 0;
  int     requests = 0;
  int     test_base = 0;
  int     next_inst = 0;
  int     outstanding = 0;
  logic   lat_check = 1'b0;
  integer seed = 32'h9e136d96;

  ls_issue_top uut (
    .clk               (clk),
    .rst               (rst),
    .flush             (flush),
    .dispatch_valid    (dispatch_valid),
    .dispatch_inst_num (dispatch_inst_num),
    .dispatch_rd       (dispatch_rd),
    .dispatch_is_store (dispatch_is_store),
    .dispatch_funct3   (dispatch_funct3),
    .dispatch_imm      (dispatch_imm),
    .dispatch_src1     (dispatch_src1),
    .dispatch_src2     (dispatch_src2),
    .wb_valid          (wb_valid),
    .wb_tag            (wb_tag),
    .wb_data           (wb_data),
    .station_full      (station_full),
    .mem_req_valid     (mem_req_valid),
    .mem_req_is_store  (mem_req_is_store),
    .mem_req_addr      (mem_req_addr),
    .mem_req_wdata     (mem_req_wdata),
    .mem_req_funct3    (mem_req_funct3),
    .mem_req_rd        (mem_req_rd),
    .mem_req_inst_num  (mem_req_inst_num)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d requests never arrived", cycles, outstanding);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Expected request and result checks
  // ----------------------------------------------------------------------
  function automatic mem_req_t expected_req(input int idx);
    mem_req_t r;
    r.addr     = shadow_val[pend_src1[idx]] + pend_imm[idx];
    r.wdata    = pend_store[idx] ? shadow_val[pend_src2[idx]] : '0;
    r.rd       = pend_rd[idx];
    r.funct3   = pend_f3[idx];
    r.is_store = pend_store[idx];
    return r;
  endfunction

  task automatic check_addr(input string name, input logic [ls_pkg::DATA_W-1:0] got,
                            input logic [ls_pkg::DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [ls_pkg::DATA_W-1:0] got,
                            input logic [ls_pkg::DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input logic [ls_pkg::TAG_W-1:0] got,
                           input logic [ls_pkg::TAG_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_funct3(input string name, input logic [ls_pkg::FUNCT3_W-1:0] got,
                              input logic [ls_pkg::FUNCT3_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_kind(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("t=%0t %s", $time, what);
  endtask

  // Scoreboard for memory requests
  always @(negedge clk) begin : monitor
    mem_req_t exp_req;
    int       idx;
    if (!rst && mem_req_valid === 1'b1) begin
      requests++;
      idx = -1;
      if (mem_req_inst_num < MAX_OPS) begin
        idx = int'(mem_req_inst_num);
      end
      if (idx < 0 || pend_state[idx] != 1) begin
        errors++;
        $display("t=%0t request for instruction %0d, which is unknown, repeated or flushed",
                 $time, mem_req_inst_num);
      end else begin
        exp_req = expected_req(idx);
        check_addr("mem_req_addr", mem_req_addr, exp_req.addr);
        check_data("mem_req_wdata", mem_req_wdata, exp_req.wdata);
        check_tag("mem_req_rd", mem_req_rd, exp_req.rd);
        check_funct3("mem_req_funct3", mem_req_funct3, exp_req.funct3);
        check_kind("mem_req_is_store", mem_req_is_store, exp_req.is_store);
        if (pend_lat[idx] && cycles - pend_edge[idx] != 2) begin
          errors++;
          $display("t=%0t instruction %0d arrived %0d cycles after dispatch instead of 2",
                   $time, idx, cycles - pend_edge[idx]);
        end
        pend_state[idx] = 2;
        use_cnt[pend_src1[idx]]--;
        use_cnt[pend_src2[idx]]--;
        outstanding--;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  task automatic advance();
    @(posedge clk);
    if (nx_disp) begin
      pend_edge[nx_inst] = cycles + 2;
    end
    dispatch_valid    <= nx_disp;
    dispatch_inst_num <= nx_inst;
    dispatch_rd       <= nx_rd;
    dispatch_is_store <= nx_store;
    dispatch_funct3   <= nx_f3;
    dispatch_imm      <= nx_imm;
    dispatch_src1     <= nx_src1;
    dispatch_src2     <= nx_src2;
    wb_valid          <= nx_wb_valid;
    wb_tag            <= nx_wb_tag;
    wb_data           <= nx_wb_data;
    flush             <= nx_flush;
    nx_disp     = 1'b0;
    nx_flush    = 1'b0;
    nx_wb_valid = '0;
  endtask

  task automatic stage_complete(input int bus, input logic [ls_pkg::TAG_W-1:0] tag,
                                input logic [ls_pkg::DATA_W-1:0] data);
    nx_wb_valid[bus] = 1'b1;
    nx_wb_tag[bus*ls_pkg::TAG_W +: ls_pkg::TAG_W]   = tag;
    nx_wb_data[bus*ls_pkg::DATA_W +: ls_pkg::DATA_W] = data;
    shadow_val[tag] = data;
    shadow_rdy[tag] = 1'b1;
  endtask

  // Load destination from the upper half that no pending entry reads
  function automatic int pick_rd();
    int start;
    int t;
    start = $unsigned($random(seed)) % 32;
    for (int k = 0; k < 32; k++) begin
      t = 32 + (start + k) % 32;
      if (shadow_rdy[t] && use_cnt[t] == 0) begin
        return t;
      end
    end
    return -1;
  endfunction

  task automatic stage_dispatch(input logic st, input logic [ls_pkg::TAG_W-1:0] s1,
                                input logic [ls_pkg::TAG_W-1:0] s2,
                                input logic [ls_pkg::FUNCT3_W-1:0] f3,
                                input logic [ls_pkg::IMM_W-1:0] imm,
                                output logic [ls_pkg::TAG_W-1:0] rd);
    int   pick;
    logic is_st;
    use_cnt[s1]++;
    use_cnt[s2]++;
    is_st = st;
    rd    = '0;
    if (!st) begin
      pick = pick_rd();
      if (pick < 0) begin
        is_st = 1'b1;
      end else begin
        rd = pick[ls_pkg::TAG_W-1:0];
        shadow_rdy[rd] = 1'b0;
      end
    end
    nx_disp  = 1'b1;
    nx_inst  = next_inst;
    nx_store = is_st;
    nx_rd    = rd;
    nx_src1  = s1;
    nx_src2  = s2;
    nx_f3    = f3;
    nx_imm   = imm;
    pend_state[next_inst] = 1;
    pend_store[next_inst] = is_st;
    pend_rd[next_inst]    = rd;
    pend_src1[next_inst]  = s1;
    pend_src2[next_inst]  = s2;
    pend_f3[next_inst]    = f3;
    pend_imm[next_inst]   = imm;
    pend_lat[next_inst]   = lat_check;
    outstanding++;
    next_inst++;
  endtask

  // A load whose destination is left waiting for a completion
  task automatic make_unready(output logic [ls_pkg::TAG_W-1:0] tag);
    stage_dispatch(1'b0, '0, '0, 3'b010, 32'h40, tag);
    advance();
  endtask

  task automatic drain();
    while (outstanding > 0) begin
      advance();
    end
  endtask

  task automatic complete_random();
    logic [31:0] r;
    int          t;
    int          start;
    for (int b = 0; b < ls_pkg::NUM_WB; b++) begin
      r = $random(seed);
      start = r[7:2];
      t = -1;
      if (r[1:0] == 2'b00) begin
        for (int k = 0; k < ls_pkg::PHYS_REGS && t < 0; k++) begin
          if (!shadow_rdy[(start + k) % ls_pkg::PHYS_REGS]) begin
            t = (start + k) % ls_pkg::PHYS_REGS;
          end
        end
      end
      if (t >= 0) begin
        stage_complete(b, t[ls_pkg::TAG_W-1:0], $random(seed));
      end
    end
  endtask

  task automatic do_flush();
    nx_flush = 1'b1;
    for (int i = 0; i < MAX_OPS; i++) begin
      if (pend_state[i] == 1) begin
        pend_state[i] = 3;
      end
    end
    for (int t = 0; t < ls_pkg::PHYS_REGS; t++) begin
      shadow_rdy[t] = 1'b1;
      use_cnt[t]    = 0;
    end
    outstanding = 0;
  endtask

  task automatic finish_test(input string name);
    $display("test %s %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main
    logic [ls_pkg::TAG_W-1:0] u [4];
    logic [ls_pkg::TAG_W-1:0] rd_w;
    logic [ls_pkg::TAG_W-1:0] dummy;
    logic [31:0]              r;
    int                       n;
    rst = 1'b1;
    flush = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_inst_num = '0;
    dispatch_rd = '0;
    dispatch_is_store = 1'b0;
    dispatch_funct3 = '0;
    dispatch_imm = '0;
    dispatch_src1 = '0;
    dispatch_src2 = '0;
    wb_valid = '0;
    wb_tag = '0;
    wb_data = '0;
    nx_disp = 1'b0;
    nx_flush = 1'b0;
    nx_wb_valid = '0;
    nx_wb_tag = '0;
    nx_wb_data = '0;
    for (int t = 0; t < ls_pkg::PHYS_REGS; t++) begin
      shadow_val[t] = '0;
      shadow_rdy[t] = 1'b1;
      use_cnt[t]    = 0;
    end
    for (int i = 0; i < MAX_OPS; i++) begin
      pend_state[i] = 0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Ready sources one at a time
    for (int t = 1; t <= 8; t++) begin
      stage_complete((t - 1) % ls_pkg::NUM_WB, t, 32'h1000_0000 + t * 32'h0111_0103);
      if (t % ls_pkg::NUM_WB == 0) begin
        advance();
      end
    end
    lat_check = 1'b1;
    for (int i = 0; i < 6; i++) begin
      stage_dispatch(i[0], 1 + i, 2 + i, i[2:0], i * 32'h104 - 32'd20, dummy);
      advance();
      drain();
    end
    lat_check = 1'b0;
    finish_test("ready");

    // Wakeup on each completion bus
    for (int i = 0; i < 4; i++) begin
      make_unready(u[i]);
    end
    drain();
    for (int i = 0; i < 4; i++) begin
      stage_dispatch(i[0], u[i], u[(i + 1) % 4], 3'b010, 32'h80 + i * 8, dummy);
      advance();
    end
    repeat (6) advance();
    if (outstanding != 4) begin
      report_fail("wakeup: a request came out before its sources completed");
    end
    stage_complete(ls_pkg::WB_ALU, u[0], 32'hcafe_0010);
    stage_complete(ls_pkg::WB_MUL, u[1], 32'h0bad_f00d);
    stage_complete(ls_pkg::WB_DIV, u[2], 32'h7fff_fff0);
    stage_complete(ls_pkg::WB_LOAD, u[3], 32'h1234_5678);
    advance();
    drain();
    finish_test("wakeup");

    // Completion in the dispatch cycle
    make_unready(u[0]);
    make_unready(u[1]);
    drain();
    lat_check = 1'b1;
    stage_complete(ls_pkg::WB_DIV, u[0], 32'h0000_2000);
    stage_dispatch(1'b0, u[0], '0, 3'b100, 32'h10, dummy);
    advance();
    stage_complete(ls_pkg::WB_MUL, u[1], 32'h5555_aaaa);
    stage_dispatch(1'b1, 5, u[1], 3'b001, 32'hffff_fffc, dummy);
    advance();
    drain();
    lat_check = 1'b0;
    finish_test("bypass");

    // Fill the station with waiting entries
    make_unready(u[0]);
    drain();
    for (int i = 0; i < ls_pkg::LS_ENTRIES; i++) begin
      stage_dispatch(1'b1, u[0], 1 + i, 3'b000, i * 4, dummy);
      advance();
    end
    repeat (3) advance();
    @(negedge clk);
    if (station_full !== 1'b1 || outstanding != ls_pkg::LS_ENTRIES) begin
      report_fail("back-pressure: station_full not set with eight waiting entries");
    end
    stage_complete(ls_pkg::WB_ALU, u[0], 32'h0004_0000);
    advance();
    drain();
    advance();
    @(negedge clk);
    if (station_full !== 1'b0) begin
      report_fail("back-pressure: station_full still set after the station drained");
    end
    finish_test("full");

    // Flush waiting entries
    make_unready(u[0]);
    make_unready(u[1]);
    drain();
    stage_dispatch(1'b1, u[0], 3, 3'b010, 32'h20, dummy);
    advance();
    stage_dispatch(1'b0, u[0], u[0], 3'b000, 32'h24, rd_w);
    advance();
    stage_dispatch(1'b1, 4, u[1], 3'b001, 32'h28, dummy);
    advance();
    repeat (4) advance();
    if (outstanding != 3) begin
      report_fail("flush: a waiting instruction issued before the flush");
    end
    do_flush();
    advance();
    advance();
    stage_complete(ls_pkg::WB_LOAD, u[0], 32'hdead_0001);
    advance();
    repeat (6) advance();
    lat_check = 1'b1;
    stage_dispatch(1'b1, rd_w, u[1], 3'b010, 32'h30, dummy);
    advance();
    drain();
    lat_check = 1'b0;
    finish_test("flush");

    // Random loads and stores
    n = 0;
    while (n < RAND_OPS) begin
      complete_random();
      r = $random(seed);
      if (r[31] && outstanding < ls_pkg::LS_ENTRIES && !station_full) begin
        stage_dispatch(r[0], r[6:1], r[12:7], r[15:13], {{20{r[27]}}, r[27:16]}, dummy);
        n++;
      end
      advance();
    end
    while (outstanding > 0) begin
      complete_random();
      advance();
    end
    repeat (4) advance();
    finish_test("random");

    $display("checks %0d, requests %0d, errors %0d", checks, requests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
